/* hdl/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath widths
`define XLEN 64
`define INST_W 32

// instruction memory, one word per entry
`define IMEM_DEPTH 256
`define IMEM_AW 8

// fetch queue entries
`define FQ_DEPTH 4

// apb register map
`define APB_AW 12
`define REG_IMEM_BASE 12'h000
`define REG_IMEM_LAST 12'h3FC
`define REG_CTRL 12'h800
`define REG_STATUS 12'h804

`endif

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes the core recognises
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for the op-imm group
  typedef enum logic [2:0] {
    F3_ADDI = 3'b000,
    F3_XORI = 3'b100,
    F3_ORI  = 3'b110,
    F3_ANDI = 3'b111
  } funct3_e;

  // decoded operation, 8 bit code
  // low nibble picks the alu function inside a group
  typedef enum logic [7:0] {
    OP_NONE    = 8'h00,
    OP_ADDI    = 8'h11,
    OP_XORI    = 8'h14,
    OP_ORI     = 8'h15,
    OP_ANDI    = 8'h16,
    OP_EBREAK  = 8'h7F,
    OP_ILLEGAL = 8'hFF
  } inst_op_e;

  // ebreak is a fixed word: imm=1, rs1=0, funct3=0, rd=0
  localparam logic [24:0] EBREAK_UPPER = 25'h0002000;

  // instruction field positions
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int IMM_LSB = 20;

endpackage

/* hdl/rv_pipe_pkg.sv */
`include "rv_defines.svh"

package rv_pipe_pkg;

  // one fetched word and where it came from
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`INST_W-1:0] inst;
  } fetch_entry_t;

  // status register bit positions
  localparam int ST_RUNNING = 0;
  localparam int ST_HALTED  = 1;
  localparam int ST_ILLEGAL = 2;

  // width of the status field
  localparam int ST_W = 3;

  typedef logic [ST_W-1:0] status_t;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`APB_AW-1:0]        paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  input  logic                      halt,
  input  logic                      illegal,
  input  logic                      full,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      push_valid,
  output rv_pipe_pkg::fetch_entry_t push_data,
  output logic                      flush,
  output logic                      running
);

  logic [`INST_W-1:0] imem [`IMEM_DEPTH];
  logic [`XLEN-1:0] pc;
  logic halted;
  logic illegal_q;
  logic access;
  logic [`APB_AW-1:0] imem_off;
  logic sel_imem;
  logic sel_ctrl;
  logic sel_status;
  logic start;
  logic pc_in_range;
  rv_pipe_pkg::status_t status;

  assign access     = psel & penable;
  assign imem_off   = paddr - `REG_IMEM_BASE;
  assign sel_imem   = (imem_off <= (`REG_IMEM_LAST - `REG_IMEM_BASE)) && (paddr[1:0] == 2'b00);
  assign sel_ctrl   = (paddr == `REG_CTRL);
  assign sel_status = (paddr == `REG_STATUS);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access & ((sel_imem & pwrite & running) |
                             ~(sel_imem | sel_ctrl | sel_status));

  always_comb begin
    status = '0;
    status[rv_pipe_pkg::ST_RUNNING] = running;
    status[rv_pipe_pkg::ST_HALTED]  = halted;
    status[rv_pipe_pkg::ST_ILLEGAL] = illegal_q;
  end

  always_comb begin
    prdata = '0;
    if (sel_imem) begin
      prdata = imem[imem_off[`IMEM_AW+1:2]];
    end else if (sel_status) begin
      prdata[rv_pipe_pkg::ST_W-1:0] = status;
    end
  end

  // host loads program only while idle
  always_ff @(posedge clk) begin
    if (access && pwrite && sel_imem && !running) begin
      imem[imem_off[`IMEM_AW+1:2]] <= pwdata;
    end
  end

  // start is one-shot, a halted core stays halted until reset
  assign start = access & pwrite & sel_ctrl & pwdata[0] & ~running & ~halted;

  assign pc_in_range = (pc < `XLEN'(`IMEM_DEPTH * 4));
  assign push_valid  = running & ~halt & pc_in_range;
  assign push_data.pc   = pc;
  assign push_data.inst = imem[pc[`IMEM_AW+1:2]];

  // drop whatever is queued behind the halting instruction
  assign flush = halt | illegal;

  always_ff @(posedge clk) begin
    if (reset) begin
      running   <= 1'b0;
      halted    <= 1'b0;
      illegal_q <= 1'b0;
      pc        <= '0;
    end else if (running && halt) begin
      running   <= 1'b0;
      halted    <= 1'b1;
      illegal_q <= illegal;
    end else if (start) begin
      running <= 1'b1;
      pc      <= '0;
    end else if (push_valid && !full) begin
      pc <= pc + `XLEN'(4);
    end
  end

  a_no_push_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !push_valid);

endmodule

/* hdl/fetch_queue.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_queue #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic reset,
  input  logic flush,
  input  logic push_valid,
  input  T     push_data,
  input  logic pop_ready,
  output logic full,
  output logic pop_valid,
  output T     pop_data
);

  localparam int AW = $clog2(`FQ_DEPTH);

  T mem [`FQ_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0] count;
  logic do_push;
  logic do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(`FQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop_valid = (count != '0);
  assign do_pop    = pop_valid & pop_ready;
  // a slot freed by this cycle's pop can be refilled at once
  assign full      = (count == (AW+1)'(`FQ_DEPTH)) & ~do_pop;
  assign do_push   = push_valid & ~full;
  assign pop_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a blocked push must not overrun the buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= (AW+1)'(`FQ_DEPTH));

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop_ready |-> pop_valid);

endmodule

/* hdl/idu.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module idu (
  input  logic [`INST_W-1:0]    inst,
  output rv_isa_pkg::inst_op_e  op,
  output logic [4:0]            rs1_addr,
  output logic [4:0]            rs2_addr,
  output logic [4:0]            rd_addr,
  output logic [`XLEN-1:0]      imm,
  output logic                  rd_we
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_e funct3;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [11:0] imm12;

  // field split
  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3 = rv_isa_pkg::funct3_e'(inst[rv_isa_pkg::F3_LSB +: 3]);
  assign rd     = inst[rv_isa_pkg::RD_LSB +: 5];
  assign rs1    = inst[rv_isa_pkg::RS1_LSB +: 5];
  assign imm12  = inst[rv_isa_pkg::IMM_LSB +: 12];

  always_comb begin
    op = rv_isa_pkg::OP_ILLEGAL;
    if (opcode == rv_isa_pkg::OPC_OP_IMM) begin
      case (funct3)
        rv_isa_pkg::F3_ADDI: op = rv_isa_pkg::OP_ADDI;
        rv_isa_pkg::F3_XORI: op = rv_isa_pkg::OP_XORI;
        rv_isa_pkg::F3_ORI:  op = rv_isa_pkg::OP_ORI;
        rv_isa_pkg::F3_ANDI: op = rv_isa_pkg::OP_ANDI;
        // slti, sltiu and shifts are not supported
        default:             op = rv_isa_pkg::OP_ILLEGAL;
      endcase
    end else if (opcode == rv_isa_pkg::OPC_SYSTEM &&
                 inst[31:7] == rv_isa_pkg::EBREAK_UPPER) begin
      op = rv_isa_pkg::OP_EBREAK;
    end
  end

  // only the four alu ops write back
  assign rd_we = (op == rv_isa_pkg::OP_ADDI) || (op == rv_isa_pkg::OP_XORI) ||
                 (op == rv_isa_pkg::OP_ORI)  || (op == rv_isa_pkg::OP_ANDI);

  assign rs1_addr = rd_we ? rs1 : 5'd0;
  assign rd_addr  = rd_we ? rd : 5'd0;

  // no r-type yet, second source stays at x0
  assign rs2_addr = 5'd0;

  // sign-extended i-type immediate
  assign imm = {{(`XLEN-12){imm12[11]}}, imm12};

endmodule

/* hdl/exu.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module exu (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      running,
  input  logic                      pop_valid,
  input  rv_pipe_pkg::fetch_entry_t pop_data,
  input  logic [`XLEN-1:0]          rs1_data,
  output logic                      pop_ready,
  output logic [`INST_W-1:0]        inst,
  output logic [4:0]                rs1_addr,
  output logic                      rd_we,
  output logic [4:0]                rd_addr,
  output logic [`XLEN-1:0]          rd_wdata,
  output logic                      halt,
  output logic                      illegal
);

  rv_isa_pkg::inst_op_e dec_op;
  rv_isa_pkg::inst_op_e op;
  logic [`XLEN-1:0] imm;
  logic dec_rd_we;
  logic do_pop;

  assign inst = pop_data.inst;

  idu u_idu (
    .inst     (inst),
    .op       (dec_op),
    .rs1_addr (rs1_addr),
    .rs2_addr (),
    .rd_addr  (rd_addr),
    .imm      (imm),
    .rd_we    (dec_rd_we)
  );

  // retire one instruction per cycle while the core runs
  assign pop_ready = running & pop_valid;
  assign do_pop    = pop_ready;
  assign op        = do_pop ? dec_op : rv_isa_pkg::OP_NONE;

  always_comb begin
    case (op)
      rv_isa_pkg::OP_ADDI: rd_wdata = rs1_data + imm;
      rv_isa_pkg::OP_XORI: rd_wdata = rs1_data ^ imm;
      rv_isa_pkg::OP_ORI:  rd_wdata = rs1_data | imm;
      rv_isa_pkg::OP_ANDI: rd_wdata = rs1_data & imm;
      default:             rd_wdata = '0;
    endcase
  end

  assign rd_we   = do_pop & dec_rd_we;
  assign illegal = (op == rv_isa_pkg::OP_ILLEGAL);
  assign halt    = (op == rv_isa_pkg::OP_EBREAK) | illegal;

  // nothing behind the halting instruction may retire
  a_no_write_after_halt: assert property (@(posedge clk) disable iff (reset)
    halt |=> !rd_we && !pop_valid);

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module regfile (
  input  logic              clk,
  input  logic              reset,
  input  logic [4:0]        rs1_addr,
  input  logic [4:0]        rs2_addr,
  input  logic              we,
  input  logic [4:0]        waddr,
  input  logic [`XLEN-1:0]  wdata,
  input  logic [4:0]        dbg_addr,
  output logic [`XLEN-1:0]  rs1_data,
  output logic [`XLEN-1:0]  rs2_data,
  output logic [`XLEN-1:0]  dbg_data
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, a write shows up after the edge
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];
  assign dbg_data = regs[dbg_addr];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    we && waddr == 5'd0 |=> regs[0] == '0);

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module core_top (
  input  logic               clk,
  input  logic               reset,
  input  logic [`APB_AW-1:0] paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic [4:0]         dbg_addr,
  output logic [`XLEN-1:0]   dbg_data
);

  rv_pipe_pkg::fetch_entry_t push_data;
  rv_pipe_pkg::fetch_entry_t pop_data;
  logic push_valid;
  logic full;
  logic pop_valid;
  logic pop_ready;
  logic flush;
  logic running;
  logic halt;
  logic illegal;
  logic [4:0] rs1_addr;
  logic [`XLEN-1:0] rs1_data;
  logic rd_we;
  logic [4:0] rd_addr;
  logic [`XLEN-1:0] rd_wdata;

  fetch_unit u_fetch (
    .clk        (clk),
    .reset      (reset),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .halt       (halt),
    .illegal    (illegal),
    .full       (full),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .push_valid (push_valid),
    .push_data  (push_data),
    .flush      (flush),
    .running    (running)
  );

  fetch_queue #(.T(rv_pipe_pkg::fetch_entry_t)) u_fq (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .push_valid (push_valid),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .full       (full),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data)
  );

  exu u_exu (
    .clk       (clk),
    .reset     (reset),
    .running   (running),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .rs1_data  (rs1_data),
    .pop_ready (pop_ready),
    .inst      (),
    .rs1_addr  (rs1_addr),
    .rd_we     (rd_we),
    .rd_addr   (rd_addr),
    .rd_wdata  (rd_wdata),
    .halt      (halt),
    .illegal   (illegal)
  );

  // second read port parked on x0 until r-type decode exists
  regfile u_rf (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (5'd0),
    .we       (rd_we),
    .waddr    (rd_addr),
    .wdata    (rd_wdata),
    .dbg_addr (dbg_addr),
    .rs1_data (rs1_data),
    .rs2_data (),
    .dbg_data (dbg_data)
  );

endmodule

/* tb/tb_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_core;

  localparam int APB_TIMEOUT = 20;
  localparam int HALT_POLLS = 500;
  localparam logic [31:0] EBREAK_WORD = 32'h00100073;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic clk;
  logic reset;
  logic [`APB_AW-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic [4:0] dbg_addr;
  logic [`XLEN-1:0] dbg_data;

  logic [31:0] lcg_state;
  string test_name;
  logic [31:0] prog [$];
  logic [31:0] imem_shadow [`IMEM_DEPTH];
  logic [`XLEN-1:0] model_regs [32];

  core_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  // slave errors belong to the access cycle only
  a_err_in_access: assert property (@(posedge clk) disable iff (reset)
    !(psel && penable) |-> !pslverr)
    else begin
      $display("FAIL %s pslverr outside access: expected 0, actual %b", test_name, pslverr);
      abort_run();
    end

  a_dbg_x0: assert property (@(posedge clk) disable iff (reset)
    dbg_addr == 5'd0 |-> dbg_data == '0)
    else begin
      $display("FAIL %s x0 on debug port: expected 0, actual %0h", test_name, dbg_data);
      abort_run();
    end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // low lcg bits repeat quickly, take the middle ones
  function automatic int random_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[30:8]) % n;
  endfunction

  function automatic logic [31:0] encode_itype(input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic apb_transfer(input logic write, input logic [`APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    @(posedge clk);
    #1;
    paddr = addr;
    pwrite = write;
    pwdata = wdata;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      if (waits == APB_TIMEOUT) begin
        $display("timeout waiting for pready at address %0h", addr);
        abort_run();
      end
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rdata;
    apb_transfer(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic wait_halted(output logic [31:0] status);
    logic err;
    int polls;
    polls = 0;
    apb_read(`REG_STATUS, status, err);
    while (!status[rv_pipe_pkg::ST_HALTED]) begin
      if (polls == HALT_POLLS) begin
        $display("timeout waiting for the core to halt");
        abort_run();
      end
      polls++;
      apb_read(`REG_STATUS, status, err);
    end
  endtask

  // architectural result of prog, stops at the first ebreak or bad encoding
  task automatic run_model(output logic ill);
    logic [31:0] w;
    logic [63:0] imm;
    logic [63:0] src;
    logic [63:0] res;
    logic done;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    ill = 1'b0;
    done = 1'b0;
    foreach (prog[k]) begin
      w = prog[k];
      imm = {{52{w[31]}}, w[31:20]};
      src = model_regs[w[19:15]];
      res = '0;
      if (done) begin
        continue;
      end else if (w == EBREAK_WORD) begin
        done = 1'b1;
      end else if (w[6:0] != OPC_OP_IMM) begin
        done = 1'b1;
        ill = 1'b1;
      end else begin
        case (w[14:12])
          3'b000: res = src + imm;
          3'b100: res = src ^ imm;
          3'b110: res = src | imm;
          3'b111: res = src & imm;
          default: begin
            done = 1'b1;
            ill = 1'b1;
          end
        endcase
        if (!done && w[11:7] != 5'd0) model_regs[w[11:7]] = res;
      end
    end
  endtask

  task automatic launch_program(output logic ill);
    logic err;
    apply_reset();
    foreach (prog[i]) begin
      apb_write(`APB_AW'(i * 4), prog[i], err);
      check_value("program load pslverr", 64'h0, 64'(err));
      imem_shadow[i] = prog[i];
    end
    run_model(ill);
    apb_write(`REG_CTRL, 32'h1, err);
    check_value("start pslverr", 64'h0, 64'(err));
  endtask

  task automatic finish_program(input logic ill);
    logic [31:0] status;
    logic [2:0] expected;
    wait_halted(status);
    expected = '0;
    expected[rv_pipe_pkg::ST_HALTED] = 1'b1;
    expected[rv_pipe_pkg::ST_ILLEGAL] = ill;
    check_value("status", 64'(expected), 64'(status[2:0]));
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      #1;
      dbg_addr = 5'(i);
      @(negedge clk);
      check_value($sformatf("x%0d", i), model_regs[i], dbg_data);
    end
  endtask

  initial begin
    logic err;
    logic ill;
    logic [31:0] rdata;
    logic [4:0] dests [$];
    logic [4:0] src_reg;
    logic [2:0] f3_pick [3];
    lcg_state = 32'd61;
    reset = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    dbg_addr = '0;
    f3_pick[0] = 3'b100;
    f3_pick[1] = 3'b110;
    f3_pick[2] = 3'b111;
    test_name = "reset";
    apply_reset();

    test_name = "imem_rw";
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      imem_shadow[i] = next_random();
      apb_write(`APB_AW'(i * 4), imem_shadow[i], err);
      check_value("write pslverr", 64'h0, 64'(err));
    end
    for (int i = 0; i < `IMEM_DEPTH; i++) begin
      apb_read(`APB_AW'(i * 4), rdata, err);
      check_value($sformatf("imem[%0d]", i), 64'(imem_shadow[i]), 64'(rdata));
      check_value("read pslverr", 64'h0, 64'(err));
    end
    apb_write(12'h400, 32'h0, err);
    check_value("unmapped write pslverr", 64'h1, 64'(err));
    apb_read(12'h900, rdata, err);
    check_value("unmapped read pslverr", 64'h1, 64'(err));

    test_name = "addi_chain";
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      // source is x0 or an earlier destination
      if (dests.size() == 0 || random_below(4) == 0) begin
        src_reg = 5'd0;
      end else begin
        src_reg = dests[random_below(dests.size())];
      end
      dests.push_back(5'(random_below(31) + 1));
      prog.push_back(encode_itype(3'b000, dests[dests.size() - 1], src_reg,
                                  12'(next_random() >> 12)));
    end
    prog.push_back(EBREAK_WORD);
    launch_program(ill);
    finish_program(ill);

    test_name = "logic_imm";
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      // alternate the immediate sign bit
      prog.push_back(encode_itype(f3_pick[random_below(3)], 5'(random_below(31) + 1),
                                  5'(random_below(32)),
                                  {i[0], 11'(next_random() >> 9)}));
    end
    prog.push_back(EBREAK_WORD);
    launch_program(ill);
    finish_program(ill);

    test_name = "ebreak_stop";
    prog.delete();
    prog.push_back(encode_itype(3'b000, 5'd5, 5'd0, 12'd123));
    prog.push_back(encode_itype(3'b110, 5'd6, 5'd0, 12'hFF0));
    // write to x0 must be dropped
    prog.push_back(encode_itype(3'b000, 5'd0, 5'd5, 12'h07F));
    prog.push_back(EBREAK_WORD);
    prog.push_back(encode_itype(3'b000, 5'd5, 5'd0, 12'hFFF));
    prog.push_back(encode_itype(3'b100, 5'd6, 5'd6, 12'h555));
    prog.push_back(encode_itype(3'b110, 5'd9, 5'd0, 12'h001));
    launch_program(ill);
    finish_program(ill);

    test_name = "illegal_stop";
    prog.delete();
    prog.push_back(encode_itype(3'b000, 5'd7, 5'd0, 12'd55));
    prog.push_back(encode_itype(3'b111, 5'd8, 5'd7, 12'h00F));
    // slti is not in the supported set
    prog.push_back(encode_itype(3'b010, 5'd9, 5'd0, 12'h001));
    prog.push_back(encode_itype(3'b000, 5'd7, 5'd0, 12'h001));
    prog.push_back(encode_itype(3'b110, 5'd8, 5'd0, 12'hFFF));
    prog.push_back(EBREAK_WORD);
    launch_program(ill);
    finish_program(ill);

    test_name = "busy_write";
    prog.delete();
    for (int i = 0; i < 60; i++) begin
      prog.push_back(encode_itype(3'b000, 5'(random_below(31) + 1), 5'(random_below(32)),
                                  12'(next_random() >> 12)));
    end
    prog.push_back(EBREAK_WORD);
    launch_program(ill);
    apb_write(`APB_AW'(200 * 4), ~imem_shadow[200], err);
    check_value("imem write while running pslverr", 64'h1, 64'(err));
    apb_read(`REG_STATUS, rdata, err);
    check_value("running bit", 64'h1, 64'(rdata[rv_pipe_pkg::ST_RUNNING]));
    finish_program(ill);
    apb_read(`APB_AW'(200 * 4), rdata, err);
    check_value("imem[200] after blocked write", 64'(imem_shadow[200]), 64'(rdata));
    apb_write(`REG_CTRL, 32'h1, err);
    check_value("start while halted pslverr", 64'h0, 64'(err));
    apb_read(`REG_STATUS, rdata, err);
    check_value("status after second start", 64'h2, 64'(rdata[2:0]));

    $display("All tests passed!");
    $finish;
  end

endmodule

/* tb.f */
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/fetch_unit.sv
hdl/fetch_queue.sv
hdl/idu.sv
hdl/exu.sv
hdl/regfile.sv
hdl/core_top.sv
tb/tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# builds the core testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_core -o sim_tb_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_core 2>&1)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
